// File: common/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

	localparam int axi_addr_width = 32;
	localparam int data_width = 32;
	localparam int id_width = 4;
	localparam int len_width = 8;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'd0,
		BURST_INCR = 2'd1,
		BURST_WRAP = 2'd2
	} burst_e;

	// Same coding as the AXI ARSIZE field
	typedef enum logic [2:0] {
		SIZE_1B = 3'd0,
		SIZE_2B = 3'd1,
		SIZE_4B = 3'd2
	} size_e;

	typedef enum logic [1:0] {
		AR_IDLE,
		AR_VALID,
		AR_WAIT_DATA
	} ar_state_e;

	typedef enum logic [1:0] {
		R_IDLE,
		R_DATA,
		R_DONE
	} r_state_e;

	typedef struct packed {
		logic [id_width-1:0] id;
		logic [axi_addr_width-1:0] addr;
		logic [len_width-1:0] len;
		size_e size;
		burst_e burst;
	} rd_req_t;

	typedef struct packed {
		logic [id_width-1:0] arid;
		logic [axi_addr_width-1:0] araddr;
		logic [len_width-1:0] arlen;
		size_e arsize;
		burst_e arburst;
	} axi_ar_t;

	typedef struct packed {
		logic [id_width-1:0] rid;
		logic [data_width-1:0] rdata;
		logic rlast;
	} axi_r_t;

endpackage

`default_nettype wire

// File: read_channel/ar_channel.sv
`default_nettype none

module ar_channel import axi_rd_pkg::*; (
	input wire logic clk,
	input wire logic resetn,
	input wire logic req_valid,
	input rd_req_t req,
	input wire logic busy,
	input wire logic last_beat,
	output logic arvalid,
	input wire logic arready,
	output axi_ar_t ar,
	output logic ar_done,
	output rd_req_t req_q
);

	ar_state_e state, state_next;
	logic accept;

	// Requests arriving mid-transfer are dropped
	assign accept = req_valid && !busy && (state == AR_IDLE);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= AR_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			AR_IDLE: begin
				if (accept)
					state_next = AR_VALID;
			end
			AR_VALID: begin
				if (arready)
					state_next = AR_WAIT_DATA;
			end
			AR_WAIT_DATA: begin
				if (last_beat)
					state_next = AR_IDLE;
			end
			default: state_next = AR_IDLE;
		endcase
	end

	assign arvalid = (state == AR_VALID);
	assign ar_done = arvalid && arready;

	// Payload comes from the latch so it holds steady while stalled
	assign ar.arid = req_q.id;
	assign ar.araddr = req_q.addr;
	assign ar.arlen = req_q.len;
	assign ar.arsize = req_q.size;
	assign ar.arburst = req_q.burst;

endmodule

`default_nettype wire

// File: read_channel/r_channel.sv
`default_nettype none

module r_channel import axi_rd_pkg::*; #(
	parameter int mem_addr_width = 12
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic ar_done,
	input rd_req_t req_q,
	input wire logic rvalid,
	output logic rready,
	input axi_r_t r,
	output logic busy,
	output logic done,
	output logic last_beat,
	output logic load,
	output logic step,
	input wire logic [mem_addr_width-1:0] beat_addr,
	output logic wr_en,
	output logic [mem_addr_width-1:0] wr_addr,
	output logic [data_width-1:0] wr_data,
	output size_e wr_bytes
);

	r_state_e state, state_next;
	logic beat;

	assign rready = (state == R_DATA);
	assign busy = (state == R_DATA);
	assign done = (state == R_DONE);

	assign beat = rvalid && rready;
	assign last_beat = beat && r.rlast;

	// First beat address is loaded as the data phase opens
	assign load = ar_done && (state == R_IDLE);
	assign step = beat;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= R_IDLE;
			wr_en <= 1'b0;
		end else begin
			state <= state_next;
			wr_en <= beat;
		end
	end

	// Beat is turned into a memory write one cycle later
	always_ff @(posedge clk) begin
		if (beat) begin
			wr_addr <= beat_addr;
			wr_data <= r.rdata;
			wr_bytes <= req_q.size;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			R_IDLE: begin
				if (ar_done)
					state_next = R_DATA;
			end
			R_DATA: begin
				if (last_beat)
					state_next = R_DONE;
			end
			R_DONE: begin
				state_next = R_IDLE;
			end
			default: state_next = R_IDLE;
		endcase
	end

endmodule

`default_nettype wire

// File: read_channel/beat_addr_gen.sv
`default_nettype none

module beat_addr_gen import axi_rd_pkg::*; #(
	parameter int mem_addr_width = 12
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic load,
	input wire logic step,
	input rd_req_t req_q,
	output logic [mem_addr_width-1:0] beat_addr
);

	logic [mem_addr_width-1:0] beat_q;
	logic [mem_addr_width-1:0] step_bytes;
	logic [mem_addr_width-1:0] win_bytes;
	logic [mem_addr_width-1:0] next_incr;
	logic [mem_addr_width-1:0] next_addr;

	assign step_bytes = mem_addr_width'(1) << req_q.size;

	// Wrap window is (len+1) beats of 2^size bytes
	assign win_bytes = mem_addr_width'({1'b0, req_q.len} + 9'd1) << req_q.size;

	assign next_incr = beat_q + step_bytes;

	always_comb begin
		case (req_q.burst)
			BURST_FIXED: next_addr = beat_q;
			BURST_INCR: next_addr = next_incr;
			BURST_WRAP: begin
				if ((next_incr & (win_bytes - 1'b1)) == '0)
					next_addr = next_incr - win_bytes;
				else
					next_addr = next_incr;
			end
			default: next_addr = next_incr;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			beat_q <= '0;
		end else if (load) begin
			beat_q <= req_q.addr[mem_addr_width-1:0];
		end else if (step) begin
			beat_q <= next_addr;
		end
	end

	assign beat_addr = beat_q;

endmodule

`default_nettype wire

// File: verilog/read_mem.sv
`default_nettype none

module read_mem import axi_rd_pkg::*; #(
	parameter int mem_addr_width = 12
) (
	input wire logic clk,
	input wire logic wr_en,
	input wire logic [mem_addr_width-1:0] wr_addr,
	input wire logic [data_width-1:0] wr_data,
	input size_e wr_bytes,
	input wire logic [mem_addr_width-1:0] mem_addr,
	output logic [7:0] mem_data
);

	localparam int lanes = data_width / 8;

	logic [7:0] mem [2**mem_addr_width];
	logic [lanes:0] nbytes;

	assign nbytes = (lanes + 1)'(1) << wr_bytes;

	// Low lanes of the beat go to consecutive byte addresses
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int k = 0; k < lanes; k++) begin
				if (k < nbytes)
					mem[wr_addr + mem_addr_width'(k)] <= wr_data[8*k +: 8];
			end
		end
	end

	assign mem_data = mem[mem_addr];

endmodule

`default_nettype wire

// File: verilog/axi_read_master.sv
`default_nettype none

module axi_read_master import axi_rd_pkg::*; #(
	parameter int mem_addr_width = 12
) (
	input wire logic clk,
	input wire logic resetn,
	input wire logic req_valid,
	input rd_req_t req,
	output logic busy,
	output logic done,
	output logic arvalid,
	input wire logic arready,
	output axi_ar_t ar,
	input wire logic rvalid,
	output logic rready,
	input axi_r_t r,
	input wire logic [mem_addr_width-1:0] mem_addr,
	output logic [7:0] mem_data
);

	rd_req_t req_q;
	logic ar_done;
	logic last_beat;
	logic load;
	logic step;
	logic r_busy;
	logic [mem_addr_width-1:0] beat_addr;
	logic wr_en;
	logic [mem_addr_width-1:0] wr_addr;
	logic [data_width-1:0] wr_data;
	size_e wr_bytes;

	// Busy also covers the address phase, so it rises right after acceptance
	assign busy = r_busy | arvalid;

	ar_channel u_ar_channel (
		.clk(clk), .resetn(resetn),
		.req_valid(req_valid), .req(req), .busy(busy), .last_beat(last_beat),
		.arvalid(arvalid), .arready(arready), .ar(ar),
		.ar_done(ar_done), .req_q(req_q)
	);

	r_channel #(.mem_addr_width(mem_addr_width)) u_r_channel (
		.clk(clk), .resetn(resetn),
		.ar_done(ar_done), .req_q(req_q),
		.rvalid(rvalid), .rready(rready), .r(r),
		.busy(r_busy), .done(done), .last_beat(last_beat),
		.load(load), .step(step), .beat_addr(beat_addr),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_bytes(wr_bytes)
	);

	beat_addr_gen #(.mem_addr_width(mem_addr_width)) u_beat_addr_gen (
		.clk(clk), .resetn(resetn),
		.load(load), .step(step), .req_q(req_q), .beat_addr(beat_addr)
	);

	read_mem #(.mem_addr_width(mem_addr_width)) u_read_mem (
		.clk(clk),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_bytes(wr_bytes),
		.mem_addr(mem_addr), .mem_data(mem_data)
	);

endmodule

`default_nettype wire

// File: sim/axi_read_checker.sv
`default_nettype none

module axi_read_checker import axi_rd_pkg::*; (
	input wire logic clk,
	input wire logic resetn,
	input wire logic arvalid,
	input wire logic arready,
	input axi_ar_t ar,
	input wire logic rready,
	input wire logic busy,
	input wire logic done
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned failures = 0;

	// AR payload must hold while the slave stalls
	ar_hold: assert property (@(posedge clk) disable iff (!resetn)
		arvalid && !arready |=> arvalid && $stable(ar))
		else begin
			$error("arvalid dropped or ar changed before arready");
			failures++;
		end

	reset_idle: assert property (@(posedge clk)
		!resetn |-> !arvalid && !rready && !busy && !done)
		else begin
			$error("arvalid, rready, busy or done high during reset");
			failures++;
		end

	done_not_reading: assert property (@(posedge clk) disable iff (!resetn)
		!(done && rready))
		else begin
			$error("done and rready high in the same cycle");
			failures++;
		end

endmodule

`default_nettype wire

// File: sim/tb_axi_read_master.sv
`default_nettype none

module tb_axi_read_master import axi_rd_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int mem_addr_width = 12;
	localparam int timeout_cycles = 200;
	localparam string golden_file = "sim/read_golden.txt";

	logic clk;
	logic resetn;
	logic req_valid;
	rd_req_t req;
	logic busy;
	logic done;
	logic arvalid;
	logic arready;
	axi_ar_t ar;
	logic rvalid;
	logic rready;
	axi_r_t r;
	logic [mem_addr_width-1:0] mem_addr;
	logic [7:0] mem_data;

	int errors;
	int checks;
	logic [31:0] rng_state;
	rd_req_t cur;
	string test_name;
	logic [31:0] beats[$];

	axi_read_master #(.mem_addr_width(mem_addr_width)) dut_i (.*);

	bind axi_read_master axi_read_checker checker_i (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Slave stall of 0 to 3 cycles
	function automatic int next_delay();
		rng_state = xorshift(rng_state);
		return int'(rng_state[1:0]);
	endfunction

	task automatic check(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("mismatch %0s %0s expected %h actual %h", test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic wait_for(input int sel, input string what, output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < timeout_cycles; n++) begin
			@(negedge clk);
			if ((sel == 0 && arvalid) || (sel == 1 && rready) || (sel == 2 && done)) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			$display("Timeout in %0s: %0s stayed low for %0d cycles", test_name, what,
				timeout_cycles);
			errors++;
		end
	endtask

	// Issues the request in cur and plays the AXI slave for it
	task automatic run_burst();
		bit ok;
		int d;
		@(posedge clk);
		req_valid <= 1'b1;
		req <= cur;
		@(posedge clk);
		req_valid <= 1'b0;
		wait_for(0, "arvalid", ok);
		if (!ok)
			return;
		check(test_name, "busy", 1, busy);
		check(test_name, "arid", cur.id, ar.arid);
		check(test_name, "araddr", cur.addr, ar.araddr);
		check(test_name, "arlen", cur.len, ar.arlen);
		check(test_name, "arsize", cur.size, ar.arsize);
		check(test_name, "arburst", cur.burst, ar.arburst);
		d = next_delay();
		repeat (d) @(posedge clk);
		@(posedge clk);
		arready <= 1'b1;
		@(posedge clk);
		arready <= 1'b0;
		wait_for(1, "rready", ok);
		if (!ok)
			return;
		foreach (beats[i]) begin
			d = next_delay();
			repeat (d) begin
				@(posedge clk);
				rvalid <= 1'b0;
			end
			@(posedge clk);
			rvalid <= 1'b1;
			r <= '{rid: cur.id, rdata: beats[i], rlast: (i == beats.size() - 1)};
		end
		@(posedge clk);
		rvalid <= 1'b0;
		wait_for(2, "done", ok);
		// Busy drops in the same cycle as done
		if (ok)
			check(test_name, "busy", 0, busy);
	endtask

	task automatic check_byte(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		mem_addr <= addr[mem_addr_width-1:0];
		@(negedge clk);
		check(test_name, $sformatf("byte %h", addr), data, mem_data);
	endtask

	initial begin
		int fd;
		string line;
		string kw;
		string name;
		logic [31:0] v0, v1, v2, v3, v4;
		bit pending;
		resetn = 1'b0;
		req_valid = 1'b0;
		req = '0;
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		mem_addr = '0;
		errors = 0;
		checks = 0;
		rng_state = 32'h8377_60c7;
		pending = 1'b0;
		test_name = "reset";
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check("reset", "arvalid", 0, arvalid);
		check("reset", "rready", 0, rready);
		check("reset", "busy", 0, busy);
		check("reset", "done", 0, done);

		fd = $fopen(golden_file, "r");
		if (fd == 0) begin
			$display("Could not open the golden file %0s", golden_file);
			errors++;
		end else begin
			while ($fgets(line, fd) > 0) begin
				if ($sscanf(line, "%s", kw) != 1 || kw == "#")
					continue;
				if (kw == "req") begin
					if (pending)
						run_burst();
					void'($sscanf(line, "%s %s %h %h %h %h %h", kw, name, v0, v1, v2, v3, v4));
					test_name = name;
					cur.id = v0[id_width-1:0];
					cur.addr = v1;
					cur.len = v2[len_width-1:0];
					cur.size = size_e'(v3[2:0]);
					cur.burst = burst_e'(v4[1:0]);
					beats.delete();
					pending = 1'b1;
				end else if (kw == "beat") begin
					void'($sscanf(line, "%s %h", kw, v0));
					beats.push_back(v0);
				end else if (kw == "exp") begin
					// Burst runs before its first expected byte is looked up
					if (pending)
						run_burst();
					pending = 1'b0;
					void'($sscanf(line, "%s %h %h", kw, v0, v1));
					check_byte(v0, v1);
				end else begin
					$display("Golden file line not understood: %0s", line);
					errors++;
				end
			end
			if (pending)
				run_burst();
			$fclose(fd);
		end

		$display("Checks: %0d, errors: %0d, checker failures: %0d", checks, errors,
			dut_i.checker_i.failures);
		if (errors == 0 && dut_i.checker_i.failures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/read_golden.txt
# req <name> <id> <addr> <len> <size> <burst>, all hex after the name
# beat <rdata>, exp <byte address> <expected byte>
req fixed4 1 100 3 2 0
beat 11223344
beat 55667788
beat 99aabbcc
beat ddeeff01
exp 100 01
exp 103 dd
req incr1 2 100 1 0 1
beat ffffffa1
beat ffffffb2
exp 100 a1
exp 101 b2
exp 102 ee
req incr2 3 300 1 1 1
beat ffffbeef
beat ffffcafe
exp 300 ef
exp 303 ca
req incr4 4 400 1 2 1
beat 03020100
beat 07060504
exp 400 00
exp 407 07
req wrap4 5 508 3 2 2
beat 0b0a0908
beat 0f0e0d0c
beat 03020100
beat 07060504
exp 500 00
exp 50f 0f
req wrap8 6 60a 7 1 2
beat ffff0b0a
beat ffff0d0c
beat ffff0f0e
beat ffff0100
beat ffff0302
beat ffff0504
beat ffff0706
beat ffff0908
exp 600 00
exp 60b 0b
exp 60f 0f

// File: build.f
common/axi_rd_pkg.sv
read_channel/ar_channel.sv
read_channel/r_channel.sv
read_channel/beat_addr_gen.sv
verilog/read_mem.sv
verilog/axi_read_master.sv
sim/axi_read_checker.sv
sim/tb_axi_read_master.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_axi_read_master
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim_bin
	./$(BUILD_DIR)/sim_bin $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
